/* flist.f */
common/stbuf_pkg.sv
hw/store_align.sv
stbuf/stbuf_entries.sv
stbuf/stbuf_ctrl.sv
stbuf/stbuf_fwd.sv
hw/stbuf_top.sv
dv/tb_stbuf.sv

/* Makefile */
# Verilator build and run for the store buffer testbench
# override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_stbuf
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Regression failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_stbuf.sv */
//------------------------------------------------
// store buffer testbench driving a hand-built table then random steps
// a queue model cross-checks the table and drives the random phase
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_stbuf;

   import stbuf_pkg::*;

   localparam int         PERIOD     = 100;
   localparam int         MAX_CYCLES = 2000;
   localparam int         DRAIN_WAIT = 20;
   localparam int         N_ROWS     = 28;
   localparam int         N_RAND     = 40;
   localparam logic [2:0] OP_IDLE    = 3'd0;
   localparam logic [2:0] OP_ST      = 3'd1;
   localparam logic [2:0] OP_POP     = 3'd2;
   localparam logic [2:0] OP_STPOP   = 3'd3;
   localparam logic [2:0] OP_LD      = 3'd4;

   typedef struct packed {
      logic [2:0]                 op;
      logic [ADDR_W-1:0]          addr;
      ls_size_t                   size;
      logic [DATA_W-1:0]          data;
      logic [2:0]                 flags;    // empty, full, drain valid
      logic [ADDR_W-1:WORD_LSB]   dwaddr;
      logic [DATA_W-1:0]          ddata;
      logic [BYTE_W-1:0]          fbe;      // load lookup at addr
      logic [DATA_W-1:0]          fdata;
   } row_t;

   //------------------------------------------------
   // directed steps checked after the next edge
   //------------------------------------------------
   localparam row_t ROWS [N_ROWS] = '{
      // reset and first word store
      '{OP_IDLE,  16'h0100, size_byte, 32'h0, 3'b100, 14'h000, 32'h0, 4'h0, 32'h0},
      '{OP_ST,    16'h0100, size_word, 32'hdeadbeef, 3'b001, 14'h040, 32'hdeadbeef, 4'hf,
        32'hdeadbeef},
      '{OP_POP,   16'h0100, size_byte, 32'h0, 3'b100, 14'h000, 32'h0, 4'h0, 32'h0},
      // alignment
      '{OP_ST,    16'h0203, size_byte, 32'h000000a5, 3'b001, 14'h080, 32'ha5000000, 4'h8,
        32'ha5000000},
      '{OP_LD,    16'h0203, size_byte, 32'h0, 3'b001, 14'h080, 32'ha5000000, 4'h8, 32'ha5000000},
      '{OP_ST,    16'h0302, size_half, 32'h00001234, 3'b001, 14'h080, 32'ha5000000, 4'hc,
        32'h12340000},
      '{OP_POP,   16'h0302, size_byte, 32'h0, 3'b001, 14'h0c0, 32'h12340000, 4'hc, 32'h12340000},
      '{OP_POP,   16'h0302, size_byte, 32'h0, 3'b100, 14'h000, 32'h0, 4'h0, 32'h0},
      // coalescing into one word
      '{OP_ST,    16'h0400, size_byte, 32'h00000011, 3'b001, 14'h100, 32'h00000011, 4'h1,
        32'h00000011},
      '{OP_ST,    16'h0402, size_byte, 32'h00000022, 3'b001, 14'h100, 32'h00220011, 4'h5,
        32'h00220011},
      '{OP_LD,    16'h0401, size_byte, 32'h0, 3'b001, 14'h100, 32'h00220011, 4'h5, 32'h00220011},
      '{OP_ST,    16'h0402, size_byte, 32'h00000099, 3'b001, 14'h100, 32'h00990011, 4'h5,
        32'h00990011},
      '{OP_POP,   16'h0400, size_byte, 32'h0, 3'b100, 14'h000, 32'h0, 4'h0, 32'h0},
      // fill then drain in order
      '{OP_ST,    16'h0500, size_word, 32'ha0a00001, 3'b001, 14'h140, 32'ha0a00001, 4'hf,
        32'ha0a00001},
      '{OP_ST,    16'h0504, size_word, 32'ha0a00002, 3'b001, 14'h140, 32'ha0a00001, 4'hf,
        32'ha0a00002},
      '{OP_ST,    16'h0508, size_word, 32'ha0a00003, 3'b001, 14'h140, 32'ha0a00001, 4'hf,
        32'ha0a00003},
      '{OP_ST,    16'h050c, size_word, 32'ha0a00004, 3'b011, 14'h140, 32'ha0a00001, 4'hf,
        32'ha0a00004},
      '{OP_POP,   16'h0500, size_byte, 32'h0, 3'b001, 14'h141, 32'ha0a00002, 4'h0, 32'h0},
      '{OP_POP,   16'h0504, size_byte, 32'h0, 3'b001, 14'h142, 32'ha0a00003, 4'h0, 32'h0},
      '{OP_POP,   16'h0508, size_byte, 32'h0, 3'b001, 14'h143, 32'ha0a00004, 4'h0, 32'h0},
      '{OP_POP,   16'h050c, size_byte, 32'h0, 3'b100, 14'h000, 32'h0, 4'h0, 32'h0},
      // store hitting the head while it pops
      '{OP_ST,    16'h0600, size_word, 32'h55555555, 3'b001, 14'h180, 32'h55555555, 4'hf,
        32'h55555555},
      '{OP_STPOP, 16'h0601, size_byte, 32'h00000077, 3'b001, 14'h180, 32'h00007700, 4'h2,
        32'h00007700},
      '{OP_POP,   16'h0600, size_byte, 32'h0, 3'b100, 14'h000, 32'h0, 4'h0, 32'h0},
      // load misses
      '{OP_LD,    16'h0700, size_byte, 32'h0, 3'b100, 14'h000, 32'h0, 4'h0, 32'h0},
      '{OP_ST,    16'h0800, size_word, 32'hcafef00d, 3'b001, 14'h200, 32'hcafef00d, 4'hf,
        32'hcafef00d},
      '{OP_LD,    16'h0804, size_byte, 32'h0, 3'b001, 14'h200, 32'hcafef00d, 4'h0, 32'h0},
      '{OP_POP,   16'h0800, size_byte, 32'h0, 3'b100, 14'h000, 32'h0, 4'h0, 32'h0}
   };
   localparam int TEST_END [6] = '{2, 7, 12, 20, 23, 27};   // last row of each test

   logic        clk;
   logic        rst_n;
   store_req_t  st_req;
   logic        drain_pop;
   logic [ADDR_W-1:0] ld_addr;
   drain_t      drain;
   fwd_t        ld_fwd;
   logic        full;
   logic        empty;

   // reference model with the oldest entry at index 0
   logic [ADDR_W-1:WORD_LSB]  q_waddr [$];
   logic [BYTE_W-1:0]         q_be [$];
   logic [DATA_W-1:0]         q_data [$];

   int n_tests;
   int n_failed;
   int n_checks;
   int n_errors;
   int test_errors;

   stbuf_top u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .st_req    (st_req),
      .drain_pop (drain_pop),
      .ld_addr   (ld_addr),
      .drain     (drain),
      .ld_fwd    (ld_fwd),
      .full      (full),
      .empty     (empty)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   //------------------------------------------------
   // model helpers
   //------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [3:0] lanes_of(input ls_size_t size, input logic [1:0] off);
      logic [3:0] m;
      m = (size == size_word) ? 4'hf : ((size == size_half) ? 4'h3 : 4'h1);
      return m << off;
   endfunction

   function automatic logic [31:0] byte_mask(input logic [3:0] be);
      logic [31:0] m;
      for (int j = 0; j < 4; j++) begin
         m[8*j +: 8] = {8{be[j]}};
      end
      return m;
   endfunction

   // index of a live entry for the word but never a head that pops
   function automatic int find_hit(input logic [13:0] waddr, input bit popping);
      int first;
      first = (popping && q_waddr.size() > 0) ? 1 : 0;
      for (int i = first; i < q_waddr.size(); i++) begin
         if (q_waddr[i] == waddr) begin
            return i;
         end
      end
      return -1;
   endfunction

   task automatic model_step(input row_t r);
      logic [3:0]  be;
      logic [31:0] wdata;
      logic [31:0] mask;
      bit          popping;
      int          hit;
      be      = lanes_of(r.size, r.addr[1:0]);
      wdata   = r.data << (8 * int'(r.addr[1:0]));
      mask    = byte_mask(be);
      popping = (r.op == OP_POP || r.op == OP_STPOP) && q_waddr.size() > 0;
      if (r.op == OP_ST || r.op == OP_STPOP) begin
         hit = find_hit(r.addr[15:2], popping);
         if (hit < 0) begin
            q_waddr.push_back(r.addr[15:2]);
            q_be.push_back(be);
            q_data.push_back(wdata);
         end else begin
            q_data[hit] = (q_data[hit] & ~mask) | (wdata & mask);
            q_be[hit]   = q_be[hit] | be;
         end
      end
      if (popping) begin
         void'(q_waddr.pop_front());
         void'(q_be.pop_front());
         void'(q_data.pop_front());
      end
   endtask

   task automatic model_expect(input logic [15:0] addr, output row_t e);
      e = '0;
      e.flags = {q_waddr.size() == 0, q_waddr.size() == STBUF_DEPTH, q_waddr.size() > 0};
      if (q_waddr.size() > 0) begin
         e.dwaddr = q_waddr[0];
         e.ddata  = q_data[0];
      end
      for (int i = 0; i < q_waddr.size(); i++) begin
         if (q_waddr[i] == addr[15:2]) begin
            e.fbe   = e.fbe | q_be[i];
            e.fdata = e.fdata | (q_data[i] & byte_mask(q_be[i]));
         end
      end
   endtask

   //------------------------------------------------
   // checks and reporting
   //------------------------------------------------
   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      assert (got === exp) else begin
         n_errors++;
         test_errors++;
         $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic check_table(input int i, input row_t m);
      row_t t;
      bit   ok;
      t  = ROWS[i];
      ok = (m.flags == t.flags) && (m.fbe == t.fbe) && (m.fdata == t.fdata);
      if (t.flags[0]) begin
         ok = ok && (m.dwaddr == t.dwaddr) && (m.ddata == t.ddata);
      end
      n_checks++;
      assert (ok) else begin
         n_errors++;
         test_errors++;
         $display("table row %0d does not agree with the reference model", i);
      end
   endtask

   task automatic check_fwd(input row_t r);
      check_val("ld_fwd.byteen", 32'(ld_fwd.byteen), 32'(r.fbe));
      check_val("ld_fwd.data", ld_fwd.data, r.fdata);
   endtask

   function automatic string test_name(input int t);
      case (t)
         0:       return "reset and first store";
         1:       return "alignment";
         2:       return "coalescing";
         3:       return "full and drain order";
         4:       return "store with pop";
         5:       return "load miss";
         default: return "random steps";
      endcase
   endfunction

   task automatic finish_test(input string name);
      n_tests++;
      if (test_errors == 0) begin
         $display("test %0d %s: ok", n_tests, name);
      end else begin
         n_failed++;
         $display("test %0d %s: %0d errors", n_tests, name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic wait_drain_valid();
      int n;
      n = 0;
      while (!drain.valid && n < DRAIN_WAIT) begin
         @(negedge clk);
         n++;
      end
      n_checks++;
      assert (drain.valid) else begin
         n_errors++;
         test_errors++;
         $display("drain.valid stayed low for %0d cycles with stores buffered", DRAIN_WAIT);
      end
   endtask

   //------------------------------------------------
   // one step entered and left on a falling edge
   //------------------------------------------------
   task automatic do_step(input row_t r, input bit head_live);
      if (head_live && (r.op == OP_POP || r.op == OP_STPOP)) begin
         wait_drain_valid();
      end
      st_req.valid = (r.op == OP_ST || r.op == OP_STPOP);
      st_req.addr  = r.addr;
      st_req.size  = r.size;
      st_req.data  = r.data;
      drain_pop    = (r.op == OP_POP || r.op == OP_STPOP);
      ld_addr      = r.addr;
      if (r.op == OP_LD) begin
         #(PERIOD / 4);   // lookup is combinational
         check_fwd(r);
      end
      @(posedge clk);
      @(negedge clk);
      st_req.valid = 1'b0;
      drain_pop    = 1'b0;
      check_val("empty", 32'(empty), 32'(r.flags[2]));
      check_val("full", 32'(full), 32'(r.flags[1]));
      check_val("drain.valid", 32'(drain.valid), 32'(r.flags[0]));
      if (r.flags[0]) begin
         check_val("drain.waddr", 32'(drain.waddr), 32'(r.dwaddr));
         check_val("drain.data", drain.data, r.ddata);
      end
      if (r.op != OP_LD) begin
         check_fwd(r);
      end
   endtask

   // expected values straight from the model
   task automatic run_model_row(input row_t r);
      row_t m;
      bit   live;
      live = q_waddr.size() > 0;
      model_step(r);
      model_expect(r.addr, m);
      m.op   = r.op;
      m.addr = r.addr;
      m.size = r.size;
      m.data = r.data;
      do_step(m, live);
   endtask

   function automatic row_t random_row(input logic [31:0] a, input logic [31:0] b);
      row_t       r;
      logic [1:0] off;
      r = '0;
      if (a[3:0] < 4'd7) begin
         r.op = OP_ST;
      end else if (a[3:0] < 4'd10) begin
         r.op = OP_POP;
      end else if (a[3:0] < 4'd12) begin
         r.op = OP_STPOP;
      end else if (a[3:0] < 4'd14) begin
         r.op = OP_LD;
      end else begin
         r.op = OP_IDLE;
      end
      r.size = (a[5:4] == 2'd3) ? size_byte : ls_size_t'(a[5:4]);
      case (r.size)
         size_half: off = {a[7], 1'b0};   // halfwords stay even
         size_word: off = 2'b00;
         default:   off = a[7:6];
      endcase
      r.addr = {12'h090, a[9:8], off};    // four words so stores hit often
      r.data = b & byte_mask(lanes_of(r.size, 2'b00));
      return r;
   endfunction

   // watchdog
   initial begin
      for (int c = 0; c < MAX_CYCLES; c++) begin
         @(posedge clk);
      end
      $display("simulation did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
   end

   initial begin
      row_t        r;
      row_t        m;
      bit          live;
      int          t;
      logic [31:0] seed;
      logic [31:0] a;
      st_req    = '0;
      drain_pop = 1'b0;
      ld_addr   = '0;
      rst_n     = 1'b0;
      for (int c = 0; c < 10; c++) begin
         @(posedge clk);
      end
      @(negedge clk);
      rst_n = 1'b1;

      t = 0;
      for (int i = 0; i < N_ROWS; i++) begin
         r    = ROWS[i];
         live = q_waddr.size() > 0;
         model_step(r);
         model_expect(r.addr, m);
         check_table(i, m);
         do_step(r, live);
         if (i == TEST_END[t]) begin
            finish_test(test_name(t));
            t++;
         end
      end

      seed = 32'h2459_db89;
      for (int i = 0; i < N_RAND; i++) begin
         seed = xorshift(seed);
         a    = seed;
         seed = xorshift(seed);
         r    = random_row(a, seed);
         // a miss into a full buffer is never sent
         if ((r.op == OP_ST || r.op == OP_STPOP) && q_waddr.size() == STBUF_DEPTH &&
             find_hit(r.addr[15:2], r.op == OP_STPOP) < 0) begin
            r.op = OP_POP;
         end
         run_model_row(r);
      end
      while (q_waddr.size() > 0) begin
         r      = '0;
         r.op   = OP_POP;
         r.addr = 16'h0900;
         run_model_row(r);
      end
      finish_test(test_name(6));

      $display("%0d tests run, %0d failed, %0d checks, %0d errors",
               n_tests, n_failed, n_checks, n_errors);
      if (n_errors == 0 && n_failed == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hw/stbuf_top.sv */
//------------------------------------------------
// store buffer top, alignment feeding entries
// with control for drain and a lookup port for loads
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module stbuf_top (
   input  logic                          clk,
   input  logic                          rst_n,
   input  stbuf_pkg::store_req_t         st_req,
   input  logic                          drain_pop,
   input  logic [stbuf_pkg::ADDR_W-1:0]  ld_addr,
   output stbuf_pkg::drain_t             drain,
   output stbuf_pkg::fwd_t               ld_fwd,
   output logic                          full,
   output logic                          empty
);

   import stbuf_pkg::*;

   stbuf_wr_t                          wr;
   stbuf_entry_t [STBUF_DEPTH-1:0]     entries;
   logic [STBUF_PTR_W-1:0]             wr_ptr;
   logic [STBUF_PTR_W-1:0]             rd_ptr;
   logic                               pop_en;
   logic                               alloc_en;

   //------------------------------------------------
   // store path
   //------------------------------------------------
   store_align u_align (
      .req (st_req),
      .wr  (wr)
   );

   stbuf_entries u_entries (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr       (wr),
      .wr_ptr   (wr_ptr),
      .rd_ptr   (rd_ptr),
      .pop_en   (pop_en),
      .entries  (entries),
      .alloc_en (alloc_en)
   );

   // drain side and occupancy
   stbuf_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .alloc_en  (alloc_en),
      .drain_pop (drain_pop),
      .entries   (entries),
      .wr_ptr    (wr_ptr),
      .rd_ptr    (rd_ptr),
      .pop_en    (pop_en),
      .drain     (drain),
      .full      (full),
      .empty     (empty)
   );

   stbuf_fwd u_fwd (
      .ld_addr (ld_addr),
      .entries (entries),
      .fwd     (ld_fwd)
   );

endmodule

`default_nettype wire

/* stbuf/stbuf_fwd.sv */
//------------------------------------------------
// load lookup against the buffered stores
// combinational, returns the bytes the buffer owns
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module stbuf_fwd (
   input  logic [stbuf_pkg::ADDR_W-1:0]                         ld_addr,
   input  stbuf_pkg::stbuf_entry_t [stbuf_pkg::STBUF_DEPTH-1:0] entries,
   output stbuf_pkg::fwd_t                                      fwd
);

   import stbuf_pkg::*;

   logic [ADDR_W-1:WORD_LSB]   ld_waddr;
   logic [STBUF_DEPTH-1:0]     hit;

   assign ld_waddr = ld_addr[ADDR_W-1:WORD_LSB];

   //------------------------------------------------
   // word match per entry
   //------------------------------------------------
   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         hit[i] = entries[i].valid & (entries[i].waddr == ld_waddr);
      end
   end

   // OR of every hitting entry, data masked to its own lanes
   always_comb begin
      fwd = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         if (hit[i]) begin
            fwd.byteen = fwd.byteen | entries[i].byteen;
         end
         for (int j = 0; j < BYTE_W; j++) begin
            if (hit[i] & entries[i].byteen[j]) begin
               fwd.data[8*j +: 8] = fwd.data[8*j +: 8] | entries[i].data[8*j +: 8];
            end
         end
      end
   end

   // normally at most one entry hits
   // two only while a popped head and its replacement overlap

endmodule

`default_nettype wire

/* stbuf/stbuf_ctrl.sv */
//------------------------------------------------
// pointers, occupancy and in-order drain
// full and empty come from the live valid bits
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module stbuf_ctrl (
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   input  logic                                                 alloc_en,
   input  logic                                                 drain_pop,
   input  stbuf_pkg::stbuf_entry_t [stbuf_pkg::STBUF_DEPTH-1:0] entries,
   output logic [stbuf_pkg::STBUF_PTR_W-1:0]                    wr_ptr,
   output logic [stbuf_pkg::STBUF_PTR_W-1:0]                    rd_ptr,
   output logic                                                 pop_en,
   output stbuf_pkg::drain_t                                    drain,
   output logic                                                 full,
   output logic                                                 empty
);

   import stbuf_pkg::*;

   stbuf_entry_t            head;
   logic [STBUF_CNT_W-1:0]  vld_cnt;

   assign head   = entries[rd_ptr];
   assign pop_en = drain_pop & head.valid;   // pop on empty is dropped

   //------------------------------------------------
   // pointers
   //------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (alloc_en) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         end
         if (pop_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // occupancy
   always_comb begin
      vld_cnt = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         vld_cnt = vld_cnt + STBUF_CNT_W'(entries[i].valid);
      end
   end

   assign empty = (vld_cnt == '0);
   assign full  = (vld_cnt == STBUF_CNT_W'(STBUF_DEPTH));

   // head entry held until popped
   always_comb begin
      drain.valid = head.valid;
      drain.waddr = head.waddr;
      drain.data  = head.data;
   end

endmodule

`default_nettype wire

/* stbuf/stbuf_entries.sv */
//------------------------------------------------
// four store buffer entries with coalescing
// a store merges into a live entry for its word or takes wr_ptr
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module stbuf_entries (
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   input  stbuf_pkg::stbuf_wr_t                                 wr,
   input  logic [stbuf_pkg::STBUF_PTR_W-1:0]                    wr_ptr,
   input  logic [stbuf_pkg::STBUF_PTR_W-1:0]                    rd_ptr,
   input  logic                                                 pop_en,
   output stbuf_pkg::stbuf_entry_t [stbuf_pkg::STBUF_DEPTH-1:0] entries,
   output logic                                                 alloc_en
);

   import stbuf_pkg::*;

   // entry fields
   logic [STBUF_DEPTH-1:0]                          vld_q;
   logic [STBUF_DEPTH-1:0][BYTE_W-1:0]              byteen_q;
   logic [STBUF_DEPTH-1:0][ADDR_W-1:WORD_LSB]       waddr_q;
   logic [STBUF_DEPTH-1:0][DATA_W-1:0]              data_q;

   logic [STBUF_DEPTH-1:0]                          match_vec;
   logic [STBUF_DEPTH-1:0]                          pop_vec;
   logic [STBUF_DEPTH-1:0]                          wr_en;
   logic [STBUF_DEPTH-1:0][BYTE_W-1:0]              byteen_in;
   logic [STBUF_DEPTH-1:0][DATA_W-1:0]              data_in;
   logic                                            coalesce;

   //------------------------------------------------
   // coalesce match and allocation
   //------------------------------------------------
   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         pop_vec[i]   = pop_en & (rd_ptr == STBUF_PTR_W'(i));
         // the head leaving this cycle cannot take new bytes
         match_vec[i] = wr.valid & vld_q[i] & (waddr_q[i] == wr.waddr) & ~pop_vec[i];
      end
   end

   assign coalesce = |match_vec;
   assign alloc_en = wr.valid & ~coalesce;   // miss, new entry at wr_ptr

   //------------------------------------------------
   // byte-wise merge
   //------------------------------------------------
   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         wr_en[i]     = match_vec[i] | (alloc_en & (wr_ptr == STBUF_PTR_W'(i)));
         byteen_in[i] = match_vec[i] ? (byteen_q[i] | wr.byteen) : wr.byteen;
         for (int j = 0; j < BYTE_W; j++) begin
            // old lane survives only on a hit that leaves it untouched
            if (wr.byteen[j] | ~match_vec[i]) begin
               data_in[i][8*j +: 8] = wr.data[8*j +: 8];
            end else begin
               data_in[i][8*j +: 8] = data_q[i][8*j +: 8];
            end
         end
      end
   end

   // valid and byte enables
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_q    <= '0;
         byteen_q <= '0;
      end else begin
         for (int i = 0; i < STBUF_DEPTH; i++) begin
            if (pop_vec[i]) begin
               vld_q[i]    <= 1'b0;
               byteen_q[i] <= '0;
            end
            // a write to the slot being popped lands as the new tail
            if (wr_en[i]) begin
               vld_q[i]    <= 1'b1;
               byteen_q[i] <= byteen_in[i];
            end
         end
      end
   end

   // address and data payload
   always_ff @(posedge clk) begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         if (wr_en[i]) begin
            waddr_q[i] <= wr.waddr;
            data_q[i]  <= data_in[i];
         end
      end
   end

   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         entries[i].valid  = vld_q[i];
         entries[i].waddr  = waddr_q[i];
         entries[i].byteen = byteen_q[i];
         entries[i].data   = data_q[i];
      end
   end

endmodule

`default_nettype wire

/* hw/store_align.sv */
//------------------------------------------------
// lines up a committed store with its byte lanes
// purely combinational, sits in front of the entries
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module store_align (
   input  stbuf_pkg::store_req_t  req,
   output stbuf_pkg::stbuf_wr_t   wr
);

   import stbuf_pkg::*;

   logic [BYTE_W-1:0]     size_mask;   // lanes before the shift
   logic [WORD_LSB-1:0]   lane;        // starting byte lane

   assign lane = req.addr[WORD_LSB-1:0];

   //------------------------------------------------
   // size to lane mask
   //------------------------------------------------
   always_comb begin
      case (req.size)
         size_byte: size_mask = 4'b0001;
         size_half: size_mask = 4'b0011;
         size_word: size_mask = 4'b1111;
         default:   size_mask = 4'b0000;   // reserved encoding
      endcase
   end

   // stores never cross a word, so nothing falls off the top
   always_comb begin
      wr.valid  = req.valid;
      wr.waddr  = req.addr[ADDR_W-1:WORD_LSB];
      wr.byteen = size_mask << lane;
      wr.data   = req.data << {lane, 3'b000};   // eight bits per lane
   end

endmodule

`default_nettype wire

/* common/stbuf_pkg.sv */
//------------------------------------------------
// shared widths, depth and struct types for the store buffer
// import with stbuf_pkg::* inside each module body
//------------------------------------------------
`default_nettype none

package stbuf_pkg;

   //------------------------------------------------
   // sizes
   //------------------------------------------------
   localparam int STBUF_DEPTH = 4;
   localparam int STBUF_PTR_W = 2;
   localparam int STBUF_CNT_W = 3;   // holds 0..4
   localparam int ADDR_W      = 16;
   localparam int DATA_W      = 32;
   localparam int BYTE_W      = 4;   // byte lanes per word
   localparam int WORD_LSB    = 2;

   typedef enum logic [1:0] {
      size_byte = 2'b00,
      size_half = 2'b01,
      size_word = 2'b10
   } ls_size_t;

   //------------------------------------------------
   // payloads
   //------------------------------------------------
   // committed store as it leaves the pipe
   typedef struct packed {
      logic                 valid;
      logic [ADDR_W-1:0]    addr;
      ls_size_t             size;
      logic [DATA_W-1:0]    data;
   } store_req_t;

   // lane-aligned write into the entries
   typedef struct packed {
      logic                       valid;
      logic [ADDR_W-1:WORD_LSB]   waddr;
      logic [BYTE_W-1:0]          byteen;
      logic [DATA_W-1:0]          data;
   } stbuf_wr_t;

   typedef struct packed {
      logic                       valid;
      logic [ADDR_W-1:WORD_LSB]   waddr;
      logic [BYTE_W-1:0]          byteen;
      logic [DATA_W-1:0]          data;
   } stbuf_entry_t;

   typedef struct packed {
      logic                       valid;
      logic [ADDR_W-1:WORD_LSB]   waddr;
      logic [DATA_W-1:0]          data;
   } drain_t;

   typedef struct packed {
      logic [BYTE_W-1:0]    byteen;
      logic [DATA_W-1:0]    data;
   } fwd_t;

endpackage

`default_nettype wire
